// File: rtl/opn_defines.svh
`ifndef OPN_DEFINES_SVH
`define OPN_DEFINES_SVH

// clk cycles per internal clock enable
`define OPN_PRESCALE      6

// Internal enables per timer B tick
`define OPN_TMRB_PRESCALE 16

// Busy time after a data write, in clk cycles
`define OPN_BUSY_CLKS     32

// Timer counter widths
`define OPN_TMRA_W        10
`define OPN_TMRB_W        8

// Timer register numbers, bank 0 only
`define OPN_REG_TMRA_HI   8'h24
`define OPN_REG_TMRA_LO   8'h25
`define OPN_REG_TMRB      8'h26
`define OPN_REG_TMR_CTRL  8'h27

// Register 0x27 layout
// bit 0 load A, bit 1 load B, bit 2 IRQ enable A, bit 3 IRQ enable B
// bit 4 clear flag A, bit 5 clear flag B (pulses, not stored)

`endif

// File: rtl/opn_pkg.sv
`default_nettype none
`include "opn_defines.svh"

package opn_pkg;

    // Register write, one cycle wide
    typedef struct packed {
        logic       valid;
        logic       bank;   // Address bit 1 of the number write
        logic [7:0] num;
        logic [7:0] data;
    } reg_wr_t;

    // Timer settings out of the register file
    typedef struct packed {
        logic [`OPN_TMRA_W-1:0] value_a;
        logic [`OPN_TMRB_W-1:0] value_b;
        logic                   load_a;
        logic                   load_b;
        logic                   irq_en_a;
        logic                   irq_en_b;
    } timer_ctrl_t;

    typedef struct packed {
        logic flag_b;
        logic flag_a;
    } timer_flags_t;

    // Status byte as read on dout
    typedef struct packed {
        logic       busy;
        logic [4:0] zero;
        logic       flag_b;
        logic       flag_a;
    } status_t;

endpackage

`default_nettype wire

// File: rtl/opn_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "opn_defines.svh"

module opn_bus_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cs_n,
    input  logic                  wr_n,
    input  logic [1:0]            addr,
    input  logic [7:0]            din,
    input  opn_pkg::timer_flags_t flags,
    output opn_pkg::reg_wr_t      reg_wr,
    output logic [7:0]            dout
);
    import opn_pkg::*;

    localparam int BUSY_W = $clog2(`OPN_BUSY_CLKS + 1);

    logic              write;
    logic              num_wr;
    logic              data_wr;
    logic [7:0]        num_q;
    logic              bank_q;
    logic              wr_valid;
    logic              wr_bank;
    logic [7:0]        wr_num;
    logic [7:0]        wr_data;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;
    status_t           status;

    assign write   = !cs_n && !wr_n;
    assign num_wr  = write && !addr[0];
    assign data_wr = write && addr[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            num_q    <= '0;
            bank_q   <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= data_wr;    // Single cycle strobe
            if (num_wr) begin
                num_q  <= din;
                bank_q <= addr[1];
            end
        end
    end

    // Write payload, taken with the latched number
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_bank <= bank_q;
            wr_num  <= num_q;
            wr_data <= din;
        end
    end

    assign reg_wr = '{valid: wr_valid, bank: wr_bank, num: wr_num, data: wr_data};

    // Busy countdown, restarted by each data write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            busy_cnt <= '0;
        else if (data_wr)
            busy_cnt <= BUSY_W'(`OPN_BUSY_CLKS);
        else if (busy)
            busy_cnt <= busy_cnt - 1'b1;
    end

    assign busy = busy_cnt != '0;

    always_comb begin
        status        = '0;
        status.busy   = busy;
        status.flag_b = flags.flag_b;
        status.flag_a = flags.flag_a;
    end

    assign dout = status;  // Same byte on every address

endmodule

`default_nettype wire

// File: rtl/opn_timer_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "opn_defines.svh"

module opn_timer_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  opn_pkg::reg_wr_t     reg_wr,
    output opn_pkg::timer_ctrl_t ctrl,
    output logic                 clr_a,
    output logic                 clr_b
);
    logic                   wr_en;
    logic [7:0]             value_a_hi;
    logic [1:0]             value_a_lo;
    logic [`OPN_TMRB_W-1:0] value_b;
    logic                   load_a;
    logic                   load_b;
    logic                   irq_en_a;
    logic                   irq_en_b;

    // Timer registers live in bank 0 only
    assign wr_en = reg_wr.valid && !reg_wr.bank;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value_a_hi <= '0;
            value_a_lo <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
        end else begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
            if (wr_en) begin
                case (reg_wr.num)
                    `OPN_REG_TMRA_HI: value_a_hi <= reg_wr.data;
                    `OPN_REG_TMRA_LO: value_a_lo <= reg_wr.data[1:0];
                    `OPN_REG_TMRB:    value_b    <= reg_wr.data;
                    `OPN_REG_TMR_CTRL: begin
                        load_a   <= reg_wr.data[0];
                        load_b   <= reg_wr.data[1];
                        irq_en_a <= reg_wr.data[2];
                        irq_en_b <= reg_wr.data[3];
                        clr_a    <= reg_wr.data[4];   // Flag clears are pulses
                        clr_b    <= reg_wr.data[5];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign ctrl = '{
        value_a:  {value_a_hi, value_a_lo},
        value_b:  value_b,
        load_a:   load_a,
        load_b:   load_b,
        irq_en_a: irq_en_a,
        irq_en_b: irq_en_b
    };

endmodule

`default_nettype wire

// File: rtl/opn_timer.sv
`timescale 1ns/1ps
`default_nettype none

module opn_timer #(
    parameter int WIDTH    = 10,
    parameter int TICK_DIV = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick_en,
    input  logic             load,
    input  logic [WIDTH-1:0] value,
    input  logic             irq_en,
    input  logic             clr,
    output logic             flag
);
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [WIDTH-1:0] cnt;
    logic             load_d;
    logic             start;
    logic             div_end;
    logic             tick;
    logic             ovf;

    assign start   = load && !load_d;  // Rising edge of load
    assign div_end = div_cnt == DIV_W'(TICK_DIV - 1);
    assign tick    = load && load_d && tick_en && div_end;
    assign ovf     = tick && (&cnt);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_d  <= 1'b0;
            div_cnt <= '0;
            cnt     <= '0;
        end else begin
            load_d <= load;
            if (start) begin
                div_cnt <= '0;
                cnt     <= value;
            end else if (load) begin
                if (tick_en)
                    div_cnt <= div_end ? '0 : div_cnt + 1'b1;
                if (tick)
                    cnt <= ovf ? value : cnt + 1'b1;   // Reload on overflow
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            flag <= 1'b0;
        else if (clr)
            flag <= 1'b0;   // Clear beats a same cycle overflow
        else if (ovf && irq_en)
            flag <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/opn_timer_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "opn_defines.svh"

module opn_timer_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  opn_pkg::timer_ctrl_t  ctrl,
    input  logic                  clr_a,
    input  logic                  clr_b,
    output opn_pkg::timer_flags_t flags,
    output logic                  irq_n
);
    localparam int PRE_W = $clog2(`OPN_PRESCALE);

    logic [PRE_W-1:0] pre_cnt;
    logic             clk_en;
    logic             flag_a;
    logic             flag_b;

    // Internal clock enable, one clk in OPN_PRESCALE
    assign clk_en = pre_cnt == PRE_W'(`OPN_PRESCALE - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pre_cnt <= '0;
        else
            pre_cnt <= clk_en ? '0 : pre_cnt + 1'b1;
    end

    opn_timer #(.WIDTH(`OPN_TMRA_W), .TICK_DIV(1)) u_tmr_a (
        .clk     ( clk           ),
        .arst_n  ( arst_n        ),
        .tick_en ( clk_en        ),
        .load    ( ctrl.load_a   ),
        .value   ( ctrl.value_a  ),
        .irq_en  ( ctrl.irq_en_a ),
        .clr     ( clr_a         ),
        .flag    ( flag_a        )
    );

    opn_timer #(.WIDTH(`OPN_TMRB_W), .TICK_DIV(`OPN_TMRB_PRESCALE)) u_tmr_b (
        .clk     ( clk           ),
        .arst_n  ( arst_n        ),
        .tick_en ( clk_en        ),
        .load    ( ctrl.load_b   ),
        .value   ( ctrl.value_b  ),
        .irq_en  ( ctrl.irq_en_b ),
        .clr     ( clr_b         ),
        .flag    ( flag_b        )
    );

    // Flags and interrupt change on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
            irq_n <= 1'b1;
        end else begin
            flags <= '{flag_b: flag_b, flag_a: flag_a};
            irq_n <= !(flag_a || flag_b);
        end
    end

endmodule

`default_nettype wire

// File: rtl/opn_top.sv
`timescale 1ns/1ps
`default_nettype none

module opn_top (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       irq_n
);
    import opn_pkg::*;

    reg_wr_t      reg_wr;
    timer_ctrl_t  ctrl;
    timer_flags_t flags;
    logic         clr_a;
    logic         clr_b;

    opn_bus_ctrl u_bus (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .addr   ( addr   ),
        .din    ( din    ),
        .flags  ( flags  ),   // Back from the timers for status
        .reg_wr ( reg_wr ),
        .dout   ( dout   )
    );

    opn_timer_regs u_regs (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .reg_wr ( reg_wr ),
        .ctrl   ( ctrl   ),
        .clr_a  ( clr_a  ),
        .clr_b  ( clr_b  )
    );

    opn_timer_unit u_timers (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .ctrl   ( ctrl   ),
        .clr_a  ( clr_a  ),
        .clr_b  ( clr_b  ),
        .flags  ( flags  ),
        .irq_n  ( irq_n  )
    );

endmodule

`default_nettype wire

// File: tests/opn_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "opn_defines.svh"

module opn_tb;
    import opn_pkg::*;

    // Worst case waits in clk cycles
    localparam int TA_MAX  = `OPN_PRESCALE * 16 + `OPN_PRESCALE + 3;
    localparam int TB_MAX  = `OPN_PRESCALE * `OPN_TMRB_PRESCALE * 4 + `OPN_PRESCALE + 3;
    localparam int TIMEOUT = 2 * (140 + 3 * TA_MAX + 2 * TB_MAX);

    localparam timer_flags_t FLAGS_NONE = 2'b00;
    localparam timer_flags_t FLAGS_A    = 2'b01;
    localparam timer_flags_t FLAGS_B    = 2'b10;

    logic        clk;
    logic        arst_n;
    logic        cs_n;
    logic        wr_n;
    logic [1:0]  addr;
    logic [7:0]  din;
    logic [7:0]  dout;
    logic        irq_n;
    int          cycle_cnt = 0;
    int          wr_cycle = 0;      // Edge of the last data write
    int          rise_cycle = 0;    // Edge at which the last polled flag showed up
    logic        written = 1'b0;
    logic [31:0] lfsr = 32'd68203;
    int          va;

    opn_top u_dut (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .addr   ( addr   ),
        .din    ( din    ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT);
        report_error("Timeout: the tests did not finish in time");
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int period_a(input int v);
        return `OPN_PRESCALE * ((1 << `OPN_TMRA_W) - v);
    endfunction

    function automatic int period_b(input int v);
        return `OPN_PRESCALE * `OPN_TMRB_PRESCALE * ((1 << `OPN_TMRB_W) - v);
    endfunction

    function automatic status_t make_status(input logic busy, input timer_flags_t f);
        status_t s;
        s        = '0;
        s.busy   = busy;
        s.flag_b = f.flag_b;
        s.flag_a = f.flag_a;
        return s;
    endfunction

    // Busy window counted from the last data write edge
    function automatic logic exp_busy();
        return written && (cycle_cnt - wr_cycle) < `OPN_BUSY_CLKS;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_status(input status_t exp);
        if (dout !== exp)
            report_error($sformatf("MISMATCH dout: expected 0x%02h, got 0x%02h", exp, dout));
    endtask

    task automatic check_irq(input logic exp);
        if (irq_n !== exp)
            report_error($sformatf("MISMATCH irq_n: expected 0x%0h, got 0x%0h", exp, irq_n));
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= a;
        din  <= d;
        @(posedge clk);     // Write edge
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic bus_write_num(input logic bank, input logic [7:0] num);
        bus_write({bank, 1'b0}, num);
    endtask

    task automatic bus_write_data(input logic bank, input logic [7:0] data);
        bus_write({bank, 1'b1}, data);
        wr_cycle = cycle_cnt;
        written  = 1'b1;
    endtask

    task automatic reg_write(input logic bank, input logic [7:0] num, input logic [7:0] data);
        bus_write_num(bank, num);
        bus_write_data(bank, data);
    endtask

    task automatic hold_quiet(input int cycles, input timer_flags_t f);
        for (int i = 0; i < cycles; i++) begin
            check_status(make_status(exp_busy(), f));
            check_irq(!(f.flag_a || f.flag_b));
            @(negedge clk);
        end
    endtask

    // Poll one status flag with lo and hi counted in edges from the last data write
    task automatic wait_flag(input int idx, input int lo, input int hi, input timer_flags_t f);
        int n;
        n = cycle_cnt - wr_cycle;
        while (!dout[idx]) begin
            if (n > hi)
                report_error("Timer flag did not rise within its window");
            @(negedge clk);
            n = cycle_cnt - wr_cycle;
        end
        rise_cycle = cycle_cnt;
        if (n < lo)
            report_error("Timer flag rose earlier than its window allows");
        check_status(make_status(exp_busy(), f));
        check_irq(1'b0);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_status(make_status(1'b0, FLAGS_NONE));
        check_irq(1'b1);
        bus_write_num(1'b0, `OPN_REG_TMR_CTRL);     // Number only so busy stays low
        hold_quiet(8, FLAGS_NONE);
    endtask

    task automatic busy_window();
        reg_write(1'b0, 8'h30, 8'ha5);  // Not a timer register
        for (int i = 0; i < `OPN_BUSY_CLKS; i++) begin
            check_status(make_status(1'b1, FLAGS_NONE));
            @(negedge clk);
        end
        @(negedge clk);
        check_status(make_status(1'b0, FLAGS_NONE));
    endtask

    task automatic timer_a_overflow();
        int r;
        rand_bits(4, r);
        va = (1 << `OPN_TMRA_W) - 16 + r;
        reg_write(1'b0, `OPN_REG_TMRA_HI, 8'(va >> 2));
        reg_write(1'b0, `OPN_REG_TMRA_LO, 8'(va & 3));
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h05);  // load_a and irq_en_a
        wait_flag(0, period_a(va) - `OPN_PRESCALE, period_a(va) + `OPN_PRESCALE + 3, FLAGS_A);
    endtask

    task automatic flag_clear();
        int lo;
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h15);  // Keep A running and clear flag A
        lo = rise_cycle + period_a(va) - wr_cycle;  // A full reload period after the last rise
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_status(make_status(exp_busy(), FLAGS_NONE));
        check_irq(1'b1);
        wait_flag(0, lo, period_a(va) + `OPN_PRESCALE + 3, FLAGS_A);
    endtask

    task automatic timer_b_enable();
        int r;
        int vb;
        rand_bits(2, r);
        vb = (1 << `OPN_TMRB_W) - 4 + r;
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h10);  // Stop A and clear its flag
        reg_write(1'b0, `OPN_REG_TMRB, 8'(vb));
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h02);  // load_b without IRQ
        hold_quiet(period_b(vb) + `OPN_PRESCALE + 3, FLAGS_NONE);
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h0a);
        wait_flag(1, 0, period_b(vb) + `OPN_PRESCALE + 3, FLAGS_B);
    endtask

    task automatic bank1_write();
        int r;
        reg_write(1'b0, `OPN_REG_TMR_CTRL, 8'h20);
        rand_bits(4, r);
        va = (1 << `OPN_TMRA_W) - 16 + r;
        reg_write(1'b0, `OPN_REG_TMRA_HI, 8'(va >> 2));
        reg_write(1'b0, `OPN_REG_TMRA_LO, 8'(va & 3));
        reg_write(1'b1, `OPN_REG_TMR_CTRL, 8'h05);  // Bank 1 is ignored by the timers
        hold_quiet(period_a(va) + `OPN_PRESCALE + 3, FLAGS_NONE);
    endtask

    initial begin
        arst_n = 1'b0;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        addr   = 2'b00;
        din    = 8'h00;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        reset_state();
        busy_window();
        timer_a_overflow();
        flag_clear();
        timer_b_enable();
        bank1_write();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/opn_pkg.sv
rtl/opn_bus_ctrl.sv
rtl/opn_timer_regs.sv
rtl/opn_timer.sv
rtl/opn_timer_unit.sv
rtl/opn_top.sv
tests/opn_tb.sv
